//--- common/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// ------------------------------------------------------------
// Address and data
// ------------------------------------------------------------
`define CACHE_ADDR_W 32
`define CACHE_DATA_W 32

// Set index from address bits 3:2, tag from bits 31:4.
`define CACHE_SETS   4
`define CACHE_SET_W  2
`define CACHE_TAG_W  28

// ------------------------------------------------------------
// Credit channels and backing memory
// ------------------------------------------------------------
`define REQ_CREDITS  4   // Request buffer depth, equal to requester credits.
`define MEM_CREDITS  2   // Memory request buffer depth.

`define MEM_WORDS    256 // Indexed by address bits 9:2.
`define MEM_LATENCY  3   // Cycles from read acceptance to response.

`endif

//--- common/cache_pkg.sv
`include "cache_params.svh"

package cache_pkg;

    // ------------------------------------------------------------
    // Requester channel
    // ------------------------------------------------------------
    typedef struct packed {
        logic                     wr;
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] wdata;
    } cache_req_t;

    // For a write, rdata echoes the write data.
    typedef struct packed {
        logic [`CACHE_DATA_W-1:0] rdata;
        logic                     hit;
    } cache_rsp_t;

    // ------------------------------------------------------------
    // Backing memory channel
    // ------------------------------------------------------------
    typedef struct packed {
        logic                     wr;
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [`CACHE_DATA_W-1:0] rdata; // Sent for reads only.
    } mem_rsp_t;

endpackage

//--- design/credit_fifo.sv
`timescale 1ns/100ps

module credit_fifo #(
    parameter int  DEPTH = 4,
    parameter type T     = logic
)(
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic push_i,
    input  T     data_i,
    input  logic pop_i,
    output T     data_o,
    output logic empty_o,
    output logic credit_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty_o = (count_q == '0);
    assign full    = (count_q == CNT_W'(DEPTH));
    assign do_pop  = pop_i && !empty_o;  // A pop on an empty buffer is ignored.
    assign data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            count_q  <= count_q + CNT_W'(push_i) - CNT_W'(do_pop);
            credit_o <= do_pop;                  // One credit back per popped entry.
        end
    end

    // The sender holds DEPTH credits, so a push into a full buffer
    // means it spent a credit it never got back.
    a_no_push_when_full : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> !full
    );

endmodule

//--- cache/two_way_array.sv
`timescale 1ns/100ps
`include "cache_params.svh"

module two_way_array (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic [`CACHE_ADDR_W-1:0] addr_i,
    input  logic                     wr_en_i,
    input  logic                     wr_way_i,
    input  logic [`CACHE_DATA_W-1:0] wr_data_i,
    output logic                     hit_o,
    output logic                     hit_way_o,
    output logic [`CACHE_DATA_W-1:0] rd_data_o,
    output logic                     victim_way_o
);

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------
    logic [`CACHE_TAG_W-1:0]  tag_q  [`CACHE_SETS][2];
    logic [`CACHE_DATA_W-1:0] data_q [`CACHE_SETS][2];
    logic [`CACHE_SETS-1:0][1:0] valid_q;
    logic [`CACHE_SETS-1:0]      rr_q;     // Way to fill next in each set.

    logic [`CACHE_SET_W-1:0] cur_set;
    logic [`CACHE_TAG_W-1:0] cur_tag;
    logic                    hit0;
    logic                    hit1;

    // ------------------------------------------------------------
    // Lookup
    // ------------------------------------------------------------
    assign cur_set = addr_i[`CACHE_SET_W+1:2];
    assign cur_tag = addr_i[`CACHE_ADDR_W-1:`CACHE_ADDR_W-`CACHE_TAG_W];

    assign hit0 = valid_q[cur_set][0] && (tag_q[cur_set][0] == cur_tag);
    assign hit1 = valid_q[cur_set][1] && (tag_q[cur_set][1] == cur_tag);

    assign hit_o        = hit0 || hit1;
    assign hit_way_o    = hit1;
    assign rd_data_o    = hit1 ? data_q[cur_set][1] : data_q[cur_set][0];
    assign victim_way_o = rr_q[cur_set];

    // ------------------------------------------------------------
    // Update
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_q[cur_set][wr_way_i]  <= cur_tag;
            data_q[cur_set][wr_way_i] <= wr_data_i;
        end
    end

    // A hit on way w points the bit at the other way, and a fill into
    // the named way flips it, so every write leaves the bit at ~w.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (wr_en_i) begin
            valid_q[cur_set][wr_way_i] <= 1'b1;
            rr_q[cur_set]              <= ~wr_way_i;
        end
    end

    // Fills only ever go to a way after a miss, so one tag never
    // lives in both ways of a set.
    a_single_hit : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(hit0 && hit1)
    );

endmodule

//--- cache/cache_ctrl.sv
`timescale 1ns/100ps
`include "cache_params.svh"

module cache_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     req_empty_i,
    input  cache_pkg::cache_req_t    req_i,
    input  logic                     mem_credit_i,
    input  logic                     mem_rsp_valid_i,
    input  cache_pkg::mem_rsp_t      mem_rsp_i,
    input  logic                     arr_hit_i,
    input  logic                     arr_hit_way_i,
    input  logic [`CACHE_DATA_W-1:0] arr_rd_data_i,
    input  logic                     arr_victim_way_i,
    output logic                     req_pop_o,
    output logic                     rsp_valid_o,
    output cache_pkg::cache_rsp_t    rsp_o,
    output logic                     mem_req_valid_o,
    output cache_pkg::mem_req_t      mem_req_o,
    output logic [`CACHE_ADDR_W-1:0] arr_addr_o,
    output logic                     arr_wr_en_o,
    output logic                     arr_wr_way_o,
    output logic [`CACHE_DATA_W-1:0] arr_wr_data_o
);

    localparam int CRED_W = $clog2(`MEM_CREDITS + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MEM_WAIT,
        ST_RESPOND
    } state_e;

    state_e                   state_q;
    state_e                   state_d;
    cache_pkg::cache_req_t    req_q;
    logic [`CACHE_DATA_W-1:0] fill_q;
    logic [CRED_W-1:0]        mem_cred_q;
    logic                     has_cred;

    assign has_cred   = (mem_cred_q != '0);
    assign arr_addr_o = req_q.addr;

    assign mem_req_o.wr    = req_q.wr;
    assign mem_req_o.addr  = req_q.addr;
    assign mem_req_o.wdata = req_q.wdata;

    // ------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= ST_IDLE;
            mem_cred_q <= CRED_W'(`MEM_CREDITS);
        end else begin
            state_q    <= state_d;
            mem_cred_q <= mem_cred_q + CRED_W'(mem_credit_i) - CRED_W'(mem_req_valid_o);
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_pop_o) begin
            req_q <= req_i;
        end
        if (state_q == ST_MEM_WAIT && mem_rsp_valid_i) begin
            fill_q <= mem_rsp_i.rdata;
        end
    end

    // ------------------------------------------------------------
    // Next state and outputs
    // ------------------------------------------------------------
    always_comb begin
        state_d         = state_q;
        req_pop_o       = 1'b0;
        rsp_valid_o     = 1'b0;
        mem_req_valid_o = 1'b0;
        arr_wr_en_o     = 1'b0;
        arr_wr_way_o    = arr_victim_way_i;
        arr_wr_data_o   = req_q.wdata;
        rsp_o.rdata     = req_q.wr ? req_q.wdata : arr_rd_data_i;
        rsp_o.hit       = arr_hit_i;

        case (state_q)
            ST_IDLE: begin
                if (!req_empty_i) begin
                    req_pop_o = 1'b1;
                    state_d   = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (!req_q.wr && arr_hit_i) begin
                    rsp_valid_o   = 1'b1;
                    arr_wr_en_o   = 1'b1;             // Rewrite so the set's bit follows the hit.
                    arr_wr_way_o  = arr_hit_way_i;
                    arr_wr_data_o = arr_rd_data_i;
                    state_d       = ST_IDLE;
                end else if (has_cred) begin
                    mem_req_valid_o = 1'b1;
                    if (req_q.wr) begin
                        rsp_valid_o  = 1'b1;
                        arr_wr_en_o  = 1'b1;
                        arr_wr_way_o = arr_hit_i ? arr_hit_way_i : arr_victim_way_i;
                        state_d      = ST_IDLE;
                    end else begin
                        state_d = ST_MEM_WAIT;
                    end
                end                                   // Without a credit, stay and retry.
            end
            ST_MEM_WAIT: begin
                if (mem_rsp_valid_i) begin
                    state_d = ST_RESPOND;
                end
            end
            ST_RESPOND: begin
                rsp_valid_o   = 1'b1;
                rsp_o.rdata   = fill_q;
                rsp_o.hit     = 1'b0;
                arr_wr_en_o   = 1'b1;                 // Fill the victim way.
                arr_wr_data_o = fill_q;
                state_d       = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // A credit only comes back for a request that was sent, so the count
    // never leaves the range that the memory buffer has room for.
    a_mem_credit : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        mem_cred_q <= CRED_W'(`MEM_CREDITS)
    );

endmodule

//--- design/main_mem.sv
`timescale 1ns/100ps
`include "cache_params.svh"

module main_mem (
    input  logic                rst_n_i,
    input  logic                clk_i,
    input  logic                req_valid_i,
    input  cache_pkg::mem_req_t req_i,
    output logic                credit_o,
    output logic                rsp_valid_o,
    output cache_pkg::mem_rsp_t rsp_o
);

    localparam int IDX_W = $clog2(`MEM_WORDS);
    localparam int LAT_W = $clog2(`MEM_LATENCY + 1);

    logic [`CACHE_DATA_W-1:0] mem_q [`MEM_WORDS];
    cache_pkg::mem_req_t      head;
    logic                     empty;
    logic                     pop;
    logic [IDX_W-1:0]         head_idx;
    logic [IDX_W-1:0]         rd_idx_q;
    logic [LAT_W-1:0]         lat_cnt_q;

    credit_fifo #(
        .DEPTH (`MEM_CREDITS),
        .T     (cache_pkg::mem_req_t)
    ) req_fifo_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .push_i   (req_valid_i),
        .data_i   (req_i),
        .pop_i    (pop),
        .data_o   (head),
        .empty_o  (empty),
        .credit_o (credit_o)
    );

    assign head_idx    = head.addr[IDX_W+1:2];
    assign pop         = !empty && (lat_cnt_q <= LAT_W'(1)); // Free in a read's last cycle.
    assign rsp_valid_o = (lat_cnt_q == LAT_W'(1));
    assign rsp_o.rdata = mem_q[rd_idx_q];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lat_cnt_q <= '0;
        end else if (pop && !head.wr) begin
            lat_cnt_q <= LAT_W'(`MEM_LATENCY);
        end else if (lat_cnt_q != '0) begin
            lat_cnt_q <= lat_cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop && head.wr) begin
            mem_q[head_idx] <= head.wdata;  // Writes land at the pop.
        end
        if (pop && !head.wr) begin
            rd_idx_q <= head_idx;
        end
    end

endmodule

//--- design/cache_top.sv
`timescale 1ns/100ps
`include "cache_params.svh"

module cache_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  req_valid_i,
    input  cache_pkg::cache_req_t req_i,
    output logic                  req_credit_o,
    output logic                  rsp_valid_o,
    output cache_pkg::cache_rsp_t rsp_o
);

    cache_pkg::cache_req_t    req_head;
    logic                     req_empty;
    logic                     req_pop;

    logic                     mem_req_valid;
    cache_pkg::mem_req_t      mem_req;
    logic                     mem_credit;
    logic                     mem_rsp_valid;
    cache_pkg::mem_rsp_t      mem_rsp;

    logic [`CACHE_ADDR_W-1:0] arr_addr;
    logic                     arr_wr_en;
    logic                     arr_wr_way;
    logic [`CACHE_DATA_W-1:0] arr_wr_data;
    logic                     arr_hit;
    logic                     arr_hit_way;
    logic [`CACHE_DATA_W-1:0] arr_rd_data;
    logic                     arr_victim_way;

    credit_fifo #(
        .DEPTH (`REQ_CREDITS),
        .T     (cache_pkg::cache_req_t)
    ) req_fifo_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .push_i   (req_valid_i),
        .data_i   (req_i),
        .pop_i    (req_pop),
        .data_o   (req_head),
        .empty_o  (req_empty),
        .credit_o (req_credit_o)
    );

    cache_ctrl ctrl_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .req_empty_i      (req_empty),
        .req_i            (req_head),
        .mem_credit_i     (mem_credit),
        .mem_rsp_valid_i  (mem_rsp_valid),
        .mem_rsp_i        (mem_rsp),
        .arr_hit_i        (arr_hit),
        .arr_hit_way_i    (arr_hit_way),
        .arr_rd_data_i    (arr_rd_data),
        .arr_victim_way_i (arr_victim_way),
        .req_pop_o        (req_pop),
        .rsp_valid_o      (rsp_valid_o),
        .rsp_o            (rsp_o),
        .mem_req_valid_o  (mem_req_valid),
        .mem_req_o        (mem_req),
        .arr_addr_o       (arr_addr),
        .arr_wr_en_o      (arr_wr_en),
        .arr_wr_way_o     (arr_wr_way),
        .arr_wr_data_o    (arr_wr_data)
    );

    two_way_array array_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .addr_i       (arr_addr),
        .wr_en_i      (arr_wr_en),
        .wr_way_i     (arr_wr_way),
        .wr_data_i    (arr_wr_data),
        .hit_o        (arr_hit),
        .hit_way_o    (arr_hit_way),
        .rd_data_o    (arr_rd_data),
        .victim_way_o (arr_victim_way)
    );

    main_mem mem_i (
        .rst_n_i     (rst_n_i),
        .clk_i       (clk_i),
        .req_valid_i (mem_req_valid),
        .req_i       (mem_req),
        .credit_o    (mem_credit),
        .rsp_valid_o (mem_rsp_valid),
        .rsp_o       (mem_rsp)
    );

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #5 clk_o = ~clk_o;                 // 10 ns period.
        end
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        #1 rst_n_o = 1'b1;                     // Released just after the eighth edge.
    end

endmodule

//--- dv/tb_cache_top.sv
`timescale 1ns/100ps
`include "cache_params.svh"

module tb_cache_top;

    localparam int NUM_STEPS   = 16;
    localparam int RESET_NS    = 8 * 10;
    localparam int WATCHDOG_NS = NUM_STEPS * (`MEM_LATENCY + 8) * 10 + RESET_NS;

    typedef struct packed {
        logic                     wr;
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] wdata;
        logic                     exp_hit;
        logic [`CACHE_DATA_W-1:0] exp_data;
    } step_t;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    cache_pkg::cache_req_t req;
    logic                  req_credit;
    logic                  rsp_valid;
    cache_pkg::cache_rsp_t rsp;

    step_t steps [NUM_STEPS];
    int    sent_cnt     = 0;
    int    pushed_cnt   = 0;
    int    returned_cnt = 0;
    int    rsp_cnt      = 0;

    tb_clk_gen clk_gen_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    cache_top cache_top_i (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .req_valid_i  (req_valid),
        .req_i        (req),
        .req_credit_o (req_credit),
        .rsp_valid_o  (rsp_valid),
        .rsp_o        (rsp)
    );

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic set_step(input int idx, input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic exp_hit,
                            input logic [31:0] exp_data);
        steps[idx] = '{wr, addr, wdata, exp_hit, exp_data};
    endtask

    // Set 1 holds A = 0x004, B = 0x014, C = 0x024 and D = 0x034.
    task automatic load_steps();
        set_step(0,  1'b1, 32'h0000_0004, 32'h1111_1111, 1'b0, 32'h1111_1111); // A to way 0.
        set_step(1,  1'b0, 32'h0000_0004, '0,            1'b1, 32'h1111_1111);
        set_step(2,  1'b1, 32'h0000_0014, 32'h2222_2222, 1'b0, 32'h2222_2222); // B to way 1.
        set_step(3,  1'b1, 32'h0000_0024, 32'h3333_3333, 1'b0, 32'h3333_3333); // C evicts A.
        set_step(4,  1'b0, 32'h0000_0004, '0,            1'b0, 32'h1111_1111); // A refetched.
        set_step(5,  1'b0, 32'h0000_0004, '0,            1'b1, 32'h1111_1111);
        set_step(6,  1'b1, 32'h0000_0024, 32'h4444_4444, 1'b1, 32'h4444_4444); // Write hit.
        set_step(7,  1'b1, 32'h0000_0014, 32'h5555_5555, 1'b0, 32'h5555_5555); // B evicts A.
        set_step(8,  1'b1, 32'h0000_0034, 32'h6666_6666, 1'b0, 32'h6666_6666); // D evicts C.
        set_step(9,  1'b0, 32'h0000_0024, '0,            1'b0, 32'h4444_4444); // Written through.
        set_step(10, 1'b0, 32'h0000_0024, '0,            1'b1, 32'h4444_4444);
        set_step(11, 1'b0, 32'h0000_0034, '0,            1'b1, 32'h6666_6666);
        set_step(12, 1'b1, 32'h0000_0108, 32'hA5A5_A5A5, 1'b0, 32'hA5A5_A5A5);
        set_step(13, 1'b0, 32'h0000_0108, '0,            1'b1, 32'hA5A5_A5A5);
        set_step(14, 1'b1, 32'h0000_0200, 32'hDEAD_BEEF, 1'b0, 32'hDEAD_BEEF);
        set_step(15, 1'b0, 32'h0000_0200, '0,            1'b1, 32'hDEAD_BEEF);
    endtask

    task automatic check_response();
        step_t exp;
        assert (rsp_cnt < pushed_cnt)
            else stop_with_failure("A response arrived with no request outstanding.");
        exp = steps[rsp_cnt];
        assert (rsp.hit === exp.exp_hit)
            else stop_with_failure($sformatf("MISMATCH at %0t: step %0d hit %b, expected %b",
                                             $time, rsp_cnt, rsp.hit, exp.exp_hit));
        assert (rsp.rdata === exp.exp_data)
            else stop_with_failure($sformatf("MISMATCH at %0t: step %0d data %h, expected %h",
                                             $time, rsp_cnt, rsp.rdata, exp.exp_data));
        rsp_cnt = rsp_cnt + 1;
    endtask

    // ------------------------------------------------------------
    // Stimulus, monitor and run control
    // ------------------------------------------------------------
    initial begin : stimulus
        logic [31:0] rnd;
        int          idx;
        int          gap;
        int          credits;
        rnd       = 32'h7891bb3a;
        idx       = 0;
        gap       = 0;
        req_valid = 1'b0;
        req       = '0;
        load_steps();
        @(posedge rst_n);
        while (idx < NUM_STEPS) begin
            @(posedge clk);
            #1;
            req_valid = 1'b0;
            credits   = `REQ_CREDITS - (sent_cnt - returned_cnt);
            if (gap > 0) begin
                gap = gap - 1;                 // Idle cycles let credits build up.
            end else if (credits > 0) begin
                req_valid = 1'b1;
                req.wr    = steps[idx].wr;
                req.addr  = steps[idx].addr;
                req.wdata = steps[idx].wdata;
                sent_cnt  = sent_cnt + 1;
                idx       = idx + 1;
                rnd       = xorshift32(rnd);
                gap       = int'(rnd[1:0]);
            end
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    end

    // Outputs are sampled mid-cycle, where they are settled.
    always @(negedge clk) begin
        if (req_credit) begin
            returned_cnt = returned_cnt + 1;
        end
        if (pushed_cnt == 0) begin
            assert (!rsp_valid && !req_credit)
                else stop_with_failure("Response or credit seen before any request was sent.");
        end
        if (req_valid) begin
            assert (pushed_cnt - returned_cnt < `REQ_CREDITS)
                else stop_with_failure("A request was sent with no credit left.");
            pushed_cnt = pushed_cnt + 1;
        end
        if (rsp_valid) begin
            check_response();
        end
    end

    initial begin : finish_check
        wait (rsp_cnt == NUM_STEPS);
        repeat (2) @(negedge clk);
        assert (returned_cnt == sent_cnt) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            stop_with_failure($sformatf("Credits returned (%0d) differ from requests sent (%0d).",
                                        returned_cnt, sent_cnt));
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        stop_with_failure("timeout: not all responses arrived");
    end

endmodule

//--- build.f
+incdir+common
common/cache_pkg.sv
design/credit_fifo.sv
cache/two_way_array.sv
cache/cache_ctrl.sv
design/main_mem.sv
design/cache_top.sv
dv/tb_clk_gen.sv
dv/tb_cache_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f build.f \
    --top-module tb_cache_top \
    -o sim_tb_cache_top

./obj_dir/sim_tb_cache_top > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "Testbench reported a failure, see sim.log."
    exit 1
fi

echo "Testbench finished without a failure."
